// File: trapPkg.sv
package trapPkg;

    localparam int FETCH_ID_W = 4;
    localparam int HIST_LEN = 8;

    typedef logic [FETCH_ID_W-1:0] FetchId_t;
    typedef logic [HIST_LEN-1:0] BHist_t;

    // Special flags attached by commit
    typedef enum logic [3:0] {
        FLAGS_NONE,
        FLAGS_ORDERING,
        FLAGS_FENCE,
        FLAGS_XRET,
        FLAGS_TRAP,
        FLAGS_ILLEGAL_INSTR,
        FLAGS_LD_MA,
        FLAGS_LD_AF,
        FLAGS_LD_PF,
        FLAGS_ST_MA,
        FLAGS_ST_AF,
        FLAGS_ST_PF,
        FLAGS_PRED_TAKEN,
        FLAGS_PRED_NTAKEN
    } Flags_t;

    typedef enum logic [1:0] {
        PRIV_USER = 2'd0,
        PRIV_SUPERVISOR = 2'd1,
        PRIV_MACHINE = 2'd3
    } Priv_t;

    // RISC-V synchronous exception numbers
    localparam logic [3:0] CAUSE_ILLEGAL = 4'd2;
    localparam logic [3:0] CAUSE_LD_MA = 4'd4;
    localparam logic [3:0] CAUSE_LD_AF = 4'd5;
    localparam logic [3:0] CAUSE_ST_MA = 4'd6;
    localparam logic [3:0] CAUSE_ST_AF = 4'd7;
    localparam logic [3:0] CAUSE_ECALL_U = 4'd8;
    localparam logic [3:0] CAUSE_ECALL_S = 4'd9;
    localparam logic [3:0] CAUSE_ECALL_M = 4'd11;
    localparam logic [3:0] CAUSE_LD_PF = 4'd13;
    localparam logic [3:0] CAUSE_ST_PF = 4'd15;

    // Trap codes from 16 up are not causes
    localparam logic [4:0] TRAP_V_SFENCE_VMA = 5'd16;
    localparam logic [4:0] TRAP_V_INTERRUPT = 5'd17;

    typedef union packed {
        logic [4:0] rd;
        logic [4:0] trapCode;
    } DestField_u;

    typedef struct packed {
        logic predicted;
        logic taken;
        logic isJump;
        logic [4:0] rIdx;
    } BranchPredInfo_t;

    typedef struct packed {
        logic valid;
        FetchId_t fetchId;
        logic [2:0] fetchOffs;
        logic compressed;
        DestField_u dest;
        Flags_t flags;
        logic [6:0] sqN;
    } TrapUOp_t;

    typedef struct packed {
        logic [30:0] pc;
        BHist_t hist;
        BranchPredInfo_t bpi;
        logic [2:0] branchPos;
    } PcEntry_t;

    typedef struct packed {
        Priv_t priv;
        logic [30:0] retvec;
        logic [29:0] mtvec;
        logic [29:0] stvec;
        logic [15:0] medeleg;
        logic [15:0] mideleg;
        logic interruptPending;
        logic [3:0] interruptCause;
        logic interruptDelegate;
    } TrapControl_t;

    typedef struct packed {
        logic valid;
        logic [31:0] trapPC;
        logic [3:0] cause;
        logic delegate;
        logic isInterrupt;
    } TrapInfo_t;

    typedef struct packed {
        logic taken;
        logic flush;
        logic [31:0] dstPC;
        logic [6:0] sqN;
        BHist_t history;
        logic [4:0] rIdx;
    } BranchRedirect_t;

    typedef struct packed {
        logic valid;
        logic [30:0] pc;
        logic compressed;
        BHist_t history;
        BranchPredInfo_t bpi;
        logic branchTaken;
    } BpUpdate_t;

    typedef struct packed {
        logic valid;
        logic [31:0] dstPC;
        TrapInfo_t trapInfo;
        logic isFlush;
    } TrapReq_t;

    // Halfword index of the first halfword of the instruction
    function automatic logic [30:0] instrIndex(PcEntry_t entry, TrapUOp_t instr);
        logic [30:0] idx;
        idx = {entry.pc[30:3], instr.fetchOffs};
        if (!instr.compressed) begin
            idx = idx - 31'd1;
        end
        return idx;
    endfunction

endpackage

// File: pcFile.sv
`timescale 1ns/10ps

module pcFile #(
    parameter int NUM_ENTRIES = 16
) (
    input  logic clk,
    input  logic rst,
    input  logic pcWriteEn,
    input  trapPkg::FetchId_t pcWriteId,
    input  trapPkg::PcEntry_t pcWriteData,
    input  trapPkg::FetchId_t readId,
    output trapPkg::PcEntry_t readData
);

    trapPkg::PcEntry_t entries [NUM_ENTRIES];

    // Reset forgets every stored prediction
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                entries[i].bpi.predicted <= 1'b0;
            end
        end else if (pcWriteEn) begin
            entries[pcWriteId] <= pcWriteData;
        end
    end

    assign readData = entries[readId];

    // Fetch must never hand out an ID beyond the file depth
    pcWriteIdInRange: assert property (
        @(posedge clk) disable iff (rst)
        pcWriteEn |-> (int'(pcWriteId) < NUM_ENTRIES)
    );

endmodule

// File: exceptionDecoder.sv
`timescale 1ns/10ps

module exceptionDecoder (
    input  trapPkg::TrapUOp_t instr,
    input  trapPkg::PcEntry_t pcEntry,
    input  trapPkg::TrapControl_t trapCtrl,
    output trapPkg::TrapReq_t req
);

    logic isSfence;
    logic isInterrupt;
    logic isExc;
    logic delegate;
    logic [3:0] cause;
    logic [31:0] instrPC;

    assign instrPC = {trapPkg::instrIndex(pcEntry, instr), 1'b0};

    always_comb begin
        isSfence = (instr.flags == trapPkg::FLAGS_TRAP) &&
            (instr.dest.trapCode == trapPkg::TRAP_V_SFENCE_VMA);
        isInterrupt = (instr.flags == trapPkg::FLAGS_TRAP) &&
            (instr.dest.trapCode == trapPkg::TRAP_V_INTERRUPT);
        isExc = instr.valid && !isSfence &&
            (instr.flags >= trapPkg::FLAGS_TRAP) && (instr.flags <= trapPkg::FLAGS_ST_PF);

        case (instr.flags)
            trapPkg::FLAGS_TRAP: cause = instr.dest.trapCode[3:0];
            trapPkg::FLAGS_LD_MA: cause = trapPkg::CAUSE_LD_MA;
            trapPkg::FLAGS_LD_AF: cause = trapPkg::CAUSE_LD_AF;
            trapPkg::FLAGS_LD_PF: cause = trapPkg::CAUSE_LD_PF;
            trapPkg::FLAGS_ST_MA: cause = trapPkg::CAUSE_ST_MA;
            trapPkg::FLAGS_ST_AF: cause = trapPkg::CAUSE_ST_AF;
            trapPkg::FLAGS_ST_PF: cause = trapPkg::CAUSE_ST_PF;
            default: cause = trapPkg::CAUSE_ILLEGAL;
        endcase

        if (isInterrupt) begin
            cause = trapCtrl.interruptCause;
        end else if (cause == trapPkg::CAUSE_ECALL_M) begin
            // Decode always reports ecall as coming from M-mode
            case (trapCtrl.priv)
                trapPkg::PRIV_SUPERVISOR: cause = trapPkg::CAUSE_ECALL_S;
                trapPkg::PRIV_USER: cause = trapPkg::CAUSE_ECALL_U;
                default: cause = trapPkg::CAUSE_ECALL_M;
            endcase
        end

        delegate = (trapCtrl.priv != trapPkg::PRIV_MACHINE) &&
            (isInterrupt ? trapCtrl.mideleg[cause] : trapCtrl.medeleg[cause]);

        req = '0;
        req.valid = isExc;
        req.isFlush = 1'b1;
        req.dstPC = {delegate ? trapCtrl.stvec : trapCtrl.mtvec, 2'b00};
        req.trapInfo.valid = isExc;
        req.trapInfo.trapPC = instrPC;
        req.trapInfo.cause = cause;
        req.trapInfo.delegate = delegate;
        req.trapInfo.isInterrupt = isInterrupt;
    end

endmodule

// File: flushSequencer.sv
`timescale 1ns/10ps

module flushSequencer (
    input  logic clk,
    input  logic rst,
    input  trapPkg::TrapUOp_t instr,
    input  trapPkg::PcEntry_t pcEntry,
    input  trapPkg::TrapControl_t trapCtrl,
    input  logic memBusy,
    output trapPkg::TrapReq_t req,
    output logic flushTLB,
    output logic fence,
    output logic clearICache,
    output logic disableIFetch
);

    logic memoryWait;
    logic instrFence;
    logic isSfence;
    logic isFlushOp;
    logic waitsForMem;
    logic takeInterrupt;
    logic [31:0] nextPC;
    logic [31:0] redirectPC;

    always_comb begin
        nextPC = {trapPkg::instrIndex(pcEntry, instr) +
            (instr.compressed ? 31'd1 : 31'd2), 1'b0};
        isSfence = (instr.flags == trapPkg::FLAGS_TRAP) &&
            (instr.dest.trapCode == trapPkg::TRAP_V_SFENCE_VMA);
        isFlushOp = instr.valid && (isSfence ||
            instr.flags == trapPkg::FLAGS_ORDERING ||
            instr.flags == trapPkg::FLAGS_FENCE ||
            instr.flags == trapPkg::FLAGS_XRET);
        waitsForMem = isFlushOp &&
            (instr.flags == trapPkg::FLAGS_ORDERING || instr.flags == trapPkg::FLAGS_FENCE);
        redirectPC = (instr.flags == trapPkg::FLAGS_XRET) ?
            {trapCtrl.retvec, 1'b0} : nextPC;

        // A pending interrupt becomes visible after xret or a CSR write
        takeInterrupt = isFlushOp && trapCtrl.interruptPending &&
            (instr.flags == trapPkg::FLAGS_XRET || instr.flags == trapPkg::FLAGS_ORDERING);

        req = '0;
        req.valid = isFlushOp;
        req.isFlush = 1'b1;
        req.dstPC = takeInterrupt ?
            {trapCtrl.interruptDelegate ? trapCtrl.stvec : trapCtrl.mtvec, 2'b00} : redirectPC;
        req.trapInfo.valid = takeInterrupt;
        req.trapInfo.trapPC = redirectPC;
        req.trapInfo.cause = trapCtrl.interruptCause;
        req.trapInfo.delegate = trapCtrl.interruptDelegate;
        req.trapInfo.isInterrupt = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            memoryWait <= 1'b0;
            instrFence <= 1'b0;
            flushTLB <= 1'b0;
            fence <= 1'b0;
            clearICache <= 1'b0;
        end else begin
            flushTLB <= isFlushOp && isSfence;
            fence <= isFlushOp && (instr.flags == trapPkg::FLAGS_FENCE);
            clearICache <= 1'b0;

            // Fence spends its first idle edge on the icache clear
            if (memoryWait && !memBusy) begin
                if (instrFence) begin
                    instrFence <= 1'b0;
                    clearICache <= 1'b1;
                end else begin
                    memoryWait <= 1'b0;
                end
            end

            if (waitsForMem) begin
                memoryWait <= 1'b1;
                instrFence <= (instr.flags == trapPkg::FLAGS_FENCE);
            end
        end
    end

    assign disableIFetch = memoryWait;

    clearOnlyDuringWait: assert property (
        @(posedge clk) disable iff (rst)
        $rose(clearICache) |-> memoryWait
    );

endmodule

// File: trapCombiner.sv
`timescale 1ns/10ps

module trapCombiner (
    input  logic clk,
    input  logic rst,
    input  trapPkg::TrapUOp_t instr,
    input  trapPkg::PcEntry_t pcEntry,
    input  trapPkg::TrapReq_t excReq,
    input  trapPkg::TrapReq_t flushReq,
    output trapPkg::TrapInfo_t trapInfo,
    output trapPkg::BranchRedirect_t branch,
    output trapPkg::BpUpdate_t bpUpdate
);

    trapPkg::BHist_t recHist;
    trapPkg::TrapReq_t selReq;
    logic isBranch;

    always_comb begin
        // Shift in the block's own prediction if it lies before this instruction
        if (pcEntry.bpi.predicted && !pcEntry.bpi.isJump &&
                pcEntry.branchPos < instr.fetchOffs) begin
            recHist = {pcEntry.hist[trapPkg::HIST_LEN-2:0], pcEntry.bpi.taken};
        end else begin
            recHist = pcEntry.hist;
        end

        selReq = excReq.valid ? excReq : flushReq;
        isBranch = instr.valid && (instr.flags == trapPkg::FLAGS_PRED_TAKEN ||
            instr.flags == trapPkg::FLAGS_PRED_NTAKEN);
    end

    always_ff @(posedge clk) begin
        trapInfo <= selReq.trapInfo;
        trapInfo.valid <= selReq.valid && selReq.trapInfo.valid;

        branch.taken <= selReq.valid;
        branch.flush <= selReq.valid && selReq.isFlush;
        branch.dstPC <= selReq.dstPC;
        branch.sqN <= instr.sqN;
        branch.history <= recHist;
        branch.rIdx <= pcEntry.bpi.rIdx;

        // Predictor trains on the history seen at fetch time
        bpUpdate.valid <= isBranch;
        bpUpdate.pc <= pcEntry.pc;
        bpUpdate.compressed <= instr.compressed;
        bpUpdate.history <= pcEntry.hist;
        bpUpdate.bpi <= pcEntry.bpi;
        bpUpdate.branchTaken <= (instr.flags == trapPkg::FLAGS_PRED_TAKEN);

        if (rst) begin
            trapInfo.valid <= 1'b0;
            branch.taken <= 1'b0;
            branch.flush <= 1'b0;
            bpUpdate.valid <= 1'b0;
        end
    end

    exclusiveRequests: assert property (
        @(posedge clk) disable iff (rst)
        !(excReq.valid && flushReq.valid)
    );

endmodule

// File: trapUnit.sv
`timescale 1ns/10ps

module trapUnit #(
    parameter int NUM_FETCH_IDS = 16
) (
    input  logic clk,
    input  logic rst,
    input  trapPkg::TrapUOp_t trapInstr,
    input  logic pcWriteEn,
    input  trapPkg::FetchId_t pcWriteId,
    input  trapPkg::PcEntry_t pcWriteData,
    input  trapPkg::TrapControl_t trapCtrl,
    input  logic memBusy,
    output trapPkg::TrapInfo_t trapInfo,
    output trapPkg::BranchRedirect_t branch,
    output trapPkg::BpUpdate_t bpUpdate,
    output logic flushTLB,
    output logic fence,
    output logic clearICache,
    output logic disableIFetch
);

    trapPkg::PcEntry_t pcEntry;
    trapPkg::TrapReq_t excReq;
    trapPkg::TrapReq_t flushReq;

    pcFile #(
        .NUM_ENTRIES(NUM_FETCH_IDS)
    ) pcFile0 (
        .clk(clk),
        .rst(rst),
        .pcWriteEn(pcWriteEn),
        .pcWriteId(pcWriteId),
        .pcWriteData(pcWriteData),
        .readId(trapInstr.fetchId),
        .readData(pcEntry)
    );

    exceptionDecoder excDec0 (
        .instr(trapInstr),
        .pcEntry(pcEntry),
        .trapCtrl(trapCtrl),
        .req(excReq)
    );

    flushSequencer flushSeq0 (
        .clk(clk),
        .rst(rst),
        .instr(trapInstr),
        .pcEntry(pcEntry),
        .trapCtrl(trapCtrl),
        .memBusy(memBusy),
        .req(flushReq),
        .flushTLB(flushTLB),
        .fence(fence),
        .clearICache(clearICache),
        .disableIFetch(disableIFetch)
    );

    trapCombiner comb0 (
        .clk(clk),
        .rst(rst),
        .instr(trapInstr),
        .pcEntry(pcEntry),
        .excReq(excReq),
        .flushReq(flushReq),
        .trapInfo(trapInfo),
        .branch(branch),
        .bpUpdate(bpUpdate)
    );

endmodule

// File: trapUnitTb.sv
`timescale 1ns/10ps

module trapUnitTb;

    // Tests take about 110 cycles
    localparam int MAX_CYCLES = 2000;

    logic clk;
    logic rst;
    trapPkg::TrapUOp_t trapInstr;
    logic pcWriteEn;
    trapPkg::FetchId_t pcWriteId;
    trapPkg::PcEntry_t pcWriteData;
    trapPkg::TrapControl_t trapCtrl;
    logic memBusy;
    trapPkg::TrapInfo_t trapInfo;
    trapPkg::BranchRedirect_t branch;
    trapPkg::BpUpdate_t bpUpdate;
    logic flushTLB;
    logic fence;
    logic clearICache;
    logic disableIFetch;
    int seed;
    int cycles = 0;
    int errors = 0;
    int tests = 0;

    trapUnit #(.NUM_FETCH_IDS(16)) dut0 (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic checkBit(input string what, input logic got, input logic want);
        if (got !== want) begin
            errors++;
            $display("ERROR t=%0t: %s is %b, expected %b", $time, what, got, want);
        end
    endtask

    // Payload fields only matter while the output is valid
    task automatic checkTrapInfo(input string what, input trapPkg::TrapInfo_t got,
            input trapPkg::TrapInfo_t want);
        if (want.valid ? (got !== want) : (got.valid !== 1'b0)) begin
            errors++;
            $display("ERROR t=%0t: %s trapInfo %h, expected %h", $time, what, got, want);
        end
    endtask

    task automatic checkBranch(input string what, input trapPkg::BranchRedirect_t got,
            input trapPkg::BranchRedirect_t want);
        if (want.taken ? (got !== want) : ({got.taken, got.flush} !== 2'b00)) begin
            errors++;
            $display("ERROR t=%0t: %s branch %h, expected %h", $time, what, got, want);
        end
    endtask

    task automatic checkBpUpdate(input string what, input trapPkg::BpUpdate_t got,
            input trapPkg::BpUpdate_t want);
        if (want.valid ? (got !== want) : (got.valid !== 1'b0)) begin
            errors++;
            $display("ERROR t=%0t: %s bpUpdate %h, expected %h", $time, what, got, want);
        end
    endtask

    // The offset names the last halfword, so a 32-bit instruction starts one earlier
    function automatic logic [31:0] instrAddr(trapPkg::PcEntry_t e, trapPkg::TrapUOp_t u);
        logic [31:0] addr;
        addr = {e.pc[30:3], u.fetchOffs, 1'b0};
        if (!u.compressed) begin
            addr = addr - 32'd2;
        end
        return addr;
    endfunction

    function automatic logic [31:0] nextAddr(trapPkg::PcEntry_t e, trapPkg::TrapUOp_t u);
        return instrAddr(e, u) + (u.compressed ? 32'd2 : 32'd4);
    endfunction

    function automatic trapPkg::BHist_t recoveredHist(trapPkg::PcEntry_t e,
            trapPkg::TrapUOp_t u);
        if (e.bpi.predicted && !e.bpi.isJump && (e.branchPos < u.fetchOffs)) begin
            return {e.hist[6:0], e.bpi.taken};
        end
        return e.hist;
    endfunction

    function automatic logic [31:0] vectorAddr(logic toSupervisor);
        return {toSupervisor ? trapCtrl.stvec : trapCtrl.mtvec, 2'b00};
    endfunction

    function automatic trapPkg::BranchRedirect_t redirect(logic [31:0] dst,
            trapPkg::PcEntry_t e, trapPkg::TrapUOp_t u);
        trapPkg::BranchRedirect_t r;
        r.taken = 1'b1;
        r.flush = 1'b1;
        r.dstPC = dst;
        r.sqN = u.sqN;
        r.history = recoveredHist(e, u);
        r.rIdx = e.bpi.rIdx;
        return r;
    endfunction

    function automatic trapPkg::TrapInfo_t expTrap(logic [31:0] pc, logic [3:0] cause,
            logic deleg, logic irq);
        trapPkg::TrapInfo_t t;
        t.valid = 1'b1;
        t.trapPC = pc;
        t.cause = cause;
        t.delegate = deleg;
        t.isInterrupt = irq;
        return t;
    endfunction

    task automatic randomEntry(output trapPkg::PcEntry_t e);
        logic [31:0] r;
        r = $random(seed);
        e.pc = r[30:0];
        r = $random(seed);
        e.hist = r[7:0];
        e.bpi = r[15:8];
        e.branchPos = r[18:16];
    endtask

    task automatic randomUop(input trapPkg::Flags_t flags, output trapPkg::TrapUOp_t u);
        logic [31:0] r;
        r = $random(seed);
        u = '0;
        u.valid = 1'b1;
        u.fetchId = r[3:0];
        u.fetchOffs = r[6:4];
        u.compressed = r[7];
        u.sqN = r[14:8];
        u.dest.rd = r[19:15];
        u.flags = flags;
    endtask

    // Write the block's entry, present the instruction, return once its results are out
    task automatic issue(input trapPkg::TrapUOp_t u, input trapPkg::PcEntry_t e);
        @(negedge clk);
        pcWriteEn = 1'b1;
        pcWriteId = u.fetchId;
        pcWriteData = e;
        @(negedge clk);
        pcWriteEn = 1'b0;
        trapInstr = u;
        @(negedge clk);
        trapInstr.valid = 1'b0;
    endtask

    task automatic finishTest(input string name, input int errs0);
        tests++;
        if (errors == errs0) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - errs0);
        end
    endtask

    task automatic testReset();
        int errs0;
        errs0 = errors;
        checkTrapInfo("reset", trapInfo, '0);
        checkBranch("reset", branch, '0);
        checkBpUpdate("reset", bpUpdate, '0);
        checkBit("reset flushTLB", flushTLB, 1'b0);
        checkBit("reset fence", fence, 1'b0);
        checkBit("reset clearICache", clearICache, 1'b0);
        checkBit("reset disableIFetch", disableIFetch, 1'b0);
        finishTest("reset", errs0);
    endtask

    task automatic testLoadPageFault();
        trapPkg::TrapUOp_t u;
        trapPkg::PcEntry_t e;
        int errs0;
        errs0 = errors;
        trapCtrl.priv = trapPkg::PRIV_USER;
        for (int i = 0; i < 16; i++) begin
            trapCtrl.medeleg = i[0] ? 16'h2000 : 16'h0000;
            randomUop(trapPkg::FLAGS_LD_PF, u);
            randomEntry(e);
            issue(u, e);
            checkTrapInfo("load page fault", trapInfo,
                expTrap(instrAddr(e, u), 4'd13, i[0], 1'b0));
            checkBranch("load page fault", branch, redirect(vectorAddr(i[0]), e, u));
            checkBpUpdate("load page fault", bpUpdate, '0);
        end
        trapCtrl.medeleg = '0;
        finishTest("loadPageFault", errs0);
    endtask

    task automatic checkEcall(input trapPkg::Priv_t priv, input logic [3:0] cause,
            input logic deleg);
        trapPkg::TrapUOp_t u;
        trapPkg::PcEntry_t e;
        trapCtrl.priv = priv;
        randomUop(trapPkg::FLAGS_TRAP, u);
        u.dest.trapCode = 5'd11;
        randomEntry(e);
        issue(u, e);
        checkTrapInfo("ecall", trapInfo, expTrap(instrAddr(e, u), cause, deleg, 1'b0));
        checkBranch("ecall", branch, redirect(vectorAddr(deleg), e, u));
    endtask

    task automatic testTrapCodes();
        trapPkg::TrapUOp_t u;
        trapPkg::PcEntry_t e;
        int errs0;
        errs0 = errors;
        // Bits 8 and 11 set, so M-mode shows that machine traps never delegate
        trapCtrl.medeleg = 16'h0900;
        checkEcall(trapPkg::PRIV_USER, 4'd8, 1'b1);
        checkEcall(trapPkg::PRIV_SUPERVISOR, 4'd9, 1'b0);
        checkEcall(trapPkg::PRIV_MACHINE, 4'd11, 1'b0);
        // Supervisor timer interrupt delegated through mideleg
        trapCtrl.priv = trapPkg::PRIV_SUPERVISOR;
        trapCtrl.mideleg = 16'h0020;
        trapCtrl.interruptCause = 4'd5;
        randomUop(trapPkg::FLAGS_TRAP, u);
        u.dest.trapCode = 5'd17;
        randomEntry(e);
        issue(u, e);
        checkTrapInfo("interrupt", trapInfo, expTrap(instrAddr(e, u), 4'd5, 1'b1, 1'b1));
        checkBranch("interrupt", branch, redirect(vectorAddr(1'b1), e, u));
        trapCtrl.priv = trapPkg::PRIV_MACHINE;
        trapCtrl.medeleg = '0;
        trapCtrl.mideleg = '0;
        finishTest("trapCodes", errs0);
    endtask

    task automatic testXret();
        trapPkg::TrapUOp_t u;
        trapPkg::PcEntry_t e;
        logic [31:0] r;
        logic [31:0] retAddr;
        int errs0;
        errs0 = errors;
        r = $random(seed);
        trapCtrl.retvec = r[30:0];
        retAddr = {trapCtrl.retvec, 1'b0};
        trapCtrl.interruptCause = 4'd3;
        for (int i = 0; i < 3; i++) begin
            trapCtrl.interruptPending = (i != 0);
            trapCtrl.interruptDelegate = (i == 2);
            randomUop(trapPkg::FLAGS_XRET, u);
            randomEntry(e);
            issue(u, e);
            if (i == 0) begin
                checkTrapInfo("xret", trapInfo, '0);
                checkBranch("xret", branch, redirect(retAddr, e, u));
            end else begin
                checkTrapInfo("xret interrupt", trapInfo, expTrap(retAddr, 4'd3, i == 2, 1'b1));
                checkBranch("xret interrupt", branch, redirect(vectorAddr(i == 2), e, u));
            end
        end
        trapCtrl.interruptPending = 1'b0;
        finishTest("xret", errs0);
    endtask

    task automatic testFence();
        trapPkg::TrapUOp_t u;
        trapPkg::PcEntry_t e;
        int errs0;
        errs0 = errors;
        memBusy = 1'b1;
        randomUop(trapPkg::FLAGS_FENCE, u);
        randomEntry(e);
        issue(u, e);
        checkBit("fence pulse", fence, 1'b1);
        checkBranch("fence", branch, redirect(nextAddr(e, u), e, u));
        for (int i = 0; i < 3; i++) begin
            checkBit("disableIFetch while busy", disableIFetch, 1'b1);
            checkBit("clearICache while busy", clearICache, 1'b0);
            @(negedge clk);
            checkBit("fence after pulse", fence, 1'b0);
        end
        memBusy = 1'b0;
        @(negedge clk);
        checkBit("clearICache after busy", clearICache, 1'b1);
        checkBit("disableIFetch during clear", disableIFetch, 1'b1);
        @(negedge clk);
        checkBit("clearICache single pulse", clearICache, 1'b0);
        checkBit("disableIFetch released", disableIFetch, 1'b0);
        // Ordering waits for memory but never clears the icache
        memBusy = 1'b1;
        randomUop(trapPkg::FLAGS_ORDERING, u);
        randomEntry(e);
        issue(u, e);
        checkBit("ordering fence", fence, 1'b0);
        checkBit("ordering disableIFetch", disableIFetch, 1'b1);
        checkTrapInfo("ordering", trapInfo, '0);
        checkBranch("ordering", branch, redirect(nextAddr(e, u), e, u));
        memBusy = 1'b0;
        @(negedge clk);
        checkBit("ordering clearICache", clearICache, 1'b0);
        checkBit("ordering released", disableIFetch, 1'b0);
        finishTest("fence", errs0);
    endtask

    task automatic testSfence();
        trapPkg::TrapUOp_t u;
        trapPkg::PcEntry_t e;
        int errs0;
        errs0 = errors;
        for (int i = 0; i < 2; i++) begin
            randomUop(trapPkg::FLAGS_TRAP, u);
            u.dest.trapCode = 5'd16;
            u.fetchOffs = 3'd6;
            randomEntry(e);
            e.bpi.predicted = (i == 0);
            e.bpi.isJump = 1'b0;
            e.branchPos = 3'd2;
            issue(u, e);
            checkBit("flushTLB", flushTLB, 1'b1);
            checkTrapInfo("sfence", trapInfo, '0);
            checkBranch("sfence", branch, redirect(nextAddr(e, u), e, u));
        end
        finishTest("sfence", errs0);
    endtask

    task automatic testBranchUpdate();
        trapPkg::TrapUOp_t u;
        trapPkg::PcEntry_t e;
        trapPkg::BpUpdate_t want;
        int errs0;
        errs0 = errors;
        for (int i = 0; i < 2; i++) begin
            if (i == 0) begin
                randomUop(trapPkg::FLAGS_PRED_TAKEN, u);
            end else begin
                randomUop(trapPkg::FLAGS_PRED_NTAKEN, u);
            end
            u.fetchOffs = 3'd7;
            randomEntry(e);
            e.bpi.predicted = 1'b1;
            e.bpi.isJump = 1'b0;
            e.branchPos = 3'd0;
            issue(u, e);
            want.valid = 1'b1;
            want.pc = e.pc;
            want.compressed = u.compressed;
            want.history = e.hist;
            want.bpi = e.bpi;
            want.branchTaken = (i == 0);
            checkBpUpdate("branch update", bpUpdate, want);
            checkBranch("branch update", branch, '0);
            checkTrapInfo("branch update", trapInfo, '0);
        end
        finishTest("branchUpdate", errs0);
    endtask

    initial begin
        seed = 32'hc79a5a2e;
        rst = 1'b1;
        trapInstr = '0;
        pcWriteEn = 1'b0;
        pcWriteId = '0;
        pcWriteData = '0;
        memBusy = 1'b0;
        trapCtrl = '0;
        trapCtrl.priv = trapPkg::PRIV_MACHINE;
        trapCtrl.mtvec = 30'h0000_0400;
        trapCtrl.stvec = 30'h0000_0800;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        testReset();
        testLoadPageFault();
        testTrapCodes();
        testXret();
        testFence();
        testSfence();
        testBranchUpdate();
        $display("Summary: %0d tests run, %0d errors, %0d cycles", tests, errors, cycles);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: trapUnit.f
trapPkg.sv
pcFile.sv
exceptionDecoder.sv
flushSequencer.sv
trapCombiner.sv
trapUnit.sv
trapUnitTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module trapUnitTb -f trapUnit.f -o simv

out=$(./obj_dir/simv)
echo "$out"
echo "$out" | grep -q "TEST PASSED"
